// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the cache directory testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f verilog.f \
   --top-module tb_cache_directory \
   -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

# the run counts as passed only when the log holds the pass line
grep -q "TESTS PASSED" sim.log
echo "simulation passed"

// ==== src/cache_directory.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_directory
  #(
   parameter int REP_POLICY = `POLICY_LRU                 // replacement policy code
   )
   (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                req,                       // lookup strobe, may come every cycle
   input  cache_pkg::addr_t    addr,
   input  logic                flush,                     // invalidates everything, beats req
   output logic                rsp_valid,
   output logic                rsp_hit,
   output cache_pkg::way_num_t rsp_way
   );

   cache_pkg::idx_t     idx;                              // set of the current request
   cache_pkg::way_vec_t way_hit;
   cache_pkg::way_vec_t way_valid;
   cache_pkg::way_vec_t victim_onehot;
   cache_pkg::way_vec_t fill_way;                         // fed back to both state holders

   tag_lookup u_tag_lookup (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (req),
      .flush     (flush),
      .addr      (addr),
      .fill_way  (fill_way),
      .way_hit   (way_hit),
      .way_valid (way_valid),
      .idx       (idx)
   );

   // the binary victim is not needed here, the response encodes fill_way itself
   replacement_process #(
      .REP_POLICY (REP_POLICY)
   ) u_replacement_process (
      .clk           (clk),
      .arst_n        (arst_n),
      .req           (req),
      .flush         (flush),
      .idx           (idx),
      .fill_way      (fill_way),
      .victim_onehot (victim_onehot),
      .victim_bin    ()
   );

   fill_select u_fill_select (
      .clk           (clk),
      .arst_n        (arst_n),
      .req           (req),
      .flush         (flush),
      .way_hit       (way_hit),
      .way_valid     (way_valid),
      .victim_onehot (victim_onehot),
      .fill_way      (fill_way),
      .rsp_valid     (rsp_valid),
      .rsp_hit       (rsp_hit),
      .rsp_way       (rsp_way)
   );

endmodule

// ==== src/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// directory geometry, all widths follow from these few numbers

`define CACHE_N_WAYS  4                                  // ways per set
`define CACHE_NWAY_W  2                                  // bits needed for a binary way number
`define CACHE_IDX_W   3                                  // set index bits, so 8 sets
`define CACHE_TAG_W   8                                  // tag bits kept per way

// the request address is the tag on top of the set index
`define CACHE_ADDR_W  (`CACHE_TAG_W + `CACHE_IDX_W)

// replacement policy codes, picked with the REP_POLICY parameter
`define POLICY_LRU        0                              // counter based least recently used
`define POLICY_BIT_PLRU   1                              // one MRU bit per way
`define POLICY_TREE_PLRU  2                              // binary tree of direction bits

`endif

// ==== src/cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

   // address fields, the tag sits above the set index
   typedef logic [`CACHE_ADDR_W-1:0] addr_t;              // full request address
   typedef logic [`CACHE_TAG_W-1:0]  tag_t;               // tag compared against every way
   typedef logic [`CACHE_IDX_W-1:0]  idx_t;               // selects one set

   // way encodings
   typedef logic [`CACHE_N_WAYS-1:0] way_vec_t;           // one bit per way, one-hot or a mask
   typedef logic [`CACHE_NWAY_W-1:0] way_num_t;           // binary way number

   // replacement state, one word of this per set
   typedef way_num_t [`CACHE_N_WAYS-1:0] lru_state_t;     // age counter per way, max is newest

   typedef logic [`CACHE_N_WAYS-1:0] bit_plru_state_t;    // set bit means recently used

   // heap ordered nodes, bit n-1 is node n, node 1 is the root
   typedef logic [`CACHE_N_WAYS-2:0] tree_plru_state_t;   // 0 points left, 1 points right

endpackage

// ==== src/fill_select.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module fill_select
   (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                req,
   input  logic                flush,                     // a flush cycle gives no response
   input  cache_pkg::way_vec_t way_hit,
   input  cache_pkg::way_vec_t way_valid,
   input  cache_pkg::way_vec_t victim_onehot,             // policy choice for a full set
   output cache_pkg::way_vec_t fill_way,                  // one-hot way used by this request
   output logic                rsp_valid,                 // one cycle after the request
   output logic                rsp_hit,
   output cache_pkg::way_num_t rsp_way
   );

   cache_pkg::way_vec_t free_way;                         // lowest invalid way, one-hot
   cache_pkg::way_num_t fill_bin;
   logic                rsp_load;

   always_comb
   begin
      free_way = '0;
      for (int w = `CACHE_N_WAYS - 1; w >= 0; w--)
      begin
         if (!way_valid[w])
         begin
            free_way = '0;                                // a lower free way overrides a higher one
            free_way[w] = 1'b1;
         end
      end
   end

   // hit first, then an empty way, and only a full set asks the policy
   assign fill_way = (|way_hit)  ? way_hit :
                     (|free_way) ? free_way : victim_onehot;

   onehot_to_bin #(
      .BIN_W (`CACHE_NWAY_W)
   ) u_fill_bin (
      .onehot (fill_way[`CACHE_N_WAYS-1:1]),
      .bin    (fill_bin)
   );

   assign rsp_load = req && !flush;                       // flush swallows a request in the same cycle

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rsp_valid <= 1'b0;
         rsp_hit   <= 1'b0;
         rsp_way   <= '0;
      end
      else
      begin
         rsp_valid <= rsp_load;                           // pulse lasts exactly one cycle
         if (rsp_load)
         begin
            rsp_hit <= |way_hit;
            rsp_way <= fill_bin;                          // hit way or the way that was filled
         end
      end
   end

endmodule

// ==== src/onehot_to_bin.sv ====
`timescale 1ns/1ps

module onehot_to_bin
  #(
   parameter int BIN_W = 2                                // width of the binary result
   )
   (
   input  logic [(1<<BIN_W)-1:1] onehot,                  // bit 0 is left out, it encodes as zero anyway
   output cache_pkg::way_num_t   bin
   );

   logic [BIN_W-1:0] bin_acc;                             // ORed indices of all set bits

   always_comb
   begin
      bin_acc = '0;                                       // nothing set above bit 0 means way 0
      for (int i = 1; i < (1 << BIN_W); i++)
      begin
         if (onehot[i])
         begin
            bin_acc = bin_acc | BIN_W'(i);                // a clean one-hot input sets exactly one index
         end
      end
   end

   assign bin = bin_acc;                                  // BIN_W is expected to match the way number width

endmodule

// ==== src/policy_mem.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module policy_mem
  #(
   parameter type state_t = logic                         // LRU counters, PLRU bits or tree bits
   )
   (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            clear,                         // flush, wipes every set
   input  logic            en,                            // write the addressed set
   input  cache_pkg::idx_t idx,
   input  state_t          wdata,
   output state_t          rdata
   );

   localparam int N_SETS = 1 << `CACHE_IDX_W;             // one state word per set

   state_t state_mem [N_SETS];                            // replacement state of each set

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int s = 0; s < N_SETS; s++)
         begin
            state_mem[s] <= '0;                           // zero reads as an untouched set
         end
      end
      else if (clear)
      begin
         for (int s = 0; s < N_SETS; s++)
         begin
            state_mem[s] <= '0;                           // same state as after reset
         end
      end
      else if (en)
      begin
         state_mem[idx] <= wdata;
      end
   end

   // read is combinational so the decision is made in the request cycle
   assign rdata = state_mem[idx];                         // the write lands at the same edge

endmodule

// ==== src/replacement_process.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module replacement_process
  #(
   parameter int REP_POLICY = `POLICY_LRU                 // LRU, bit PLRU or tree PLRU
   )
   (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                req,
   input  logic                flush,                     // clears the state of all sets
   input  cache_pkg::idx_t     idx,
   input  cache_pkg::way_vec_t fill_way,                  // way actually used by this request
   output cache_pkg::way_vec_t victim_onehot,             // way the policy would replace
   output cache_pkg::way_num_t victim_bin
   );

   localparam int N_WAYS = `CACHE_N_WAYS;
   localparam int NWAY_W = `CACHE_NWAY_W;

   logic state_we;                                        // every request updates its set

   assign state_we = req && !flush;

   generate
      if (REP_POLICY == `POLICY_LRU)
      begin : g_lru
         cache_pkg::lru_state_t lru_cur;                  // stored counters of the set
         cache_pkg::lru_state_t lru_init;                 // counters with the untouched default
         cache_pkg::lru_state_t lru_next;
         cache_pkg::way_num_t   used_val;                 // old counter of the used way
         cache_pkg::way_vec_t   lru_sel;

         always_comb
         begin
            used_val = '0;
            for (int w = 0; w < N_WAYS; w++)
            begin
               // an all zero word was never written, so give each way its own number
               lru_init[w] = (|lru_cur) ? lru_cur[w] : cache_pkg::way_num_t'(w);
            end
            for (int w = 0; w < N_WAYS; w++)
            begin
               if (fill_way[w])
               begin
                  used_val = used_val | lru_init[w];      // fill_way is one-hot on a request
               end
            end
            for (int w = 0; w < N_WAYS; w++)
            begin
               if (fill_way[w])
               begin
                  lru_next[w] = '1;                       // used way becomes the newest
               end
               else if (lru_init[w] > used_val)
               begin
                  lru_next[w] = lru_init[w] - cache_pkg::way_num_t'(1); // younger ways slide down
               end
               else
               begin
                  lru_next[w] = lru_init[w];              // older ways keep their age
               end
               lru_sel[w] = (lru_init[w] == '0);          // counter zero is the oldest way
            end
         end

         assign victim_onehot = lru_sel;

         policy_mem #(
            .state_t (cache_pkg::lru_state_t)
         ) u_policy_mem (
            .clk    (clk),
            .arst_n (arst_n),
            .clear  (flush),
            .en     (state_we),
            .idx    (idx),
            .wdata  (lru_next),
            .rdata  (lru_cur)
         );
      end
      else if (REP_POLICY == `POLICY_BIT_PLRU)
      begin : g_bit_plru
         cache_pkg::bit_plru_state_t mru_cur;             // set bit means recently used
         cache_pkg::bit_plru_state_t mru_set;             // current bits plus the used way
         cache_pkg::bit_plru_state_t mru_next;
         cache_pkg::way_vec_t        plru_sel;

         assign mru_set  = mru_cur | fill_way;
         assign mru_next = (&mru_set) ? '0 : mru_set;     // never store all ones, start over

         // adding one carries through the low ones and stops at the lowest clear bit
         assign plru_sel = ~mru_cur & (mru_cur + cache_pkg::bit_plru_state_t'(1));

         assign victim_onehot = plru_sel;

         policy_mem #(
            .state_t (cache_pkg::bit_plru_state_t)
         ) u_policy_mem (
            .clk    (clk),
            .arst_n (arst_n),
            .clear  (flush),
            .en     (state_we),
            .idx    (idx),
            .wdata  (mru_next),
            .rdata  (mru_cur)
         );
      end
      else
      begin : g_tree_plru
         cache_pkg::tree_plru_state_t tree_cur;           // node n is stored in bit n-1
         cache_pkg::tree_plru_state_t tree_next;
         cache_pkg::way_vec_t         tree_sel;

         always_comb
         begin : update_path
            int node;                                     // heap index of the node on the path
            tree_next = tree_cur;
            node      = 1;
            for (int w = 0; w < N_WAYS; w++)
            begin
               if (fill_way[w])
               begin
                  for (int l = 0; l < NWAY_W; l++)
                  begin
                     node = (N_WAYS + w) >> (NWAY_W - l);  // ancestor of leaf w at level l
                     tree_next[node-1] = ~w[NWAY_W-1-l];   // point to the other half
                  end
               end
            end
         end

         always_comb
         begin : follow_path
            int node;
            node = 1;                                     // start at the root
            for (int l = 0; l < NWAY_W; l++)
            begin
               node = 2 * node + int'(tree_cur[node-1]);  // 0 goes left, 1 goes right
            end
            tree_sel = '0;
            tree_sel[node - N_WAYS] = 1'b1;               // leaves are heap nodes N..2N-1
         end

         assign victim_onehot = tree_sel;

         policy_mem #(
            .state_t (cache_pkg::tree_plru_state_t)
         ) u_policy_mem (
            .clk    (clk),
            .arst_n (arst_n),
            .clear  (flush),
            .en     (state_we),
            .idx    (idx),
            .wdata  (tree_next),
            .rdata  (tree_cur)
         );
      end
   endgenerate

   onehot_to_bin #(
      .BIN_W (NWAY_W)
   ) u_victim_bin (
      .onehot (victim_onehot[N_WAYS-1:1]),
      .bin    (victim_bin)
   );

endmodule

// ==== src/tag_lookup.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module tag_lookup
   (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                req,                       // lookup strobe
   input  logic                flush,                     // drops every line, wins over req
   input  cache_pkg::addr_t    addr,
   input  cache_pkg::way_vec_t fill_way,                  // one-hot way chosen by the result stage
   output cache_pkg::way_vec_t way_hit,                   // valid ways whose tag matches
   output cache_pkg::way_vec_t way_valid,                 // valid bits of the indexed set
   output cache_pkg::idx_t     idx
   );

   localparam int N_SETS = 1 << `CACHE_IDX_W;

   cache_pkg::tag_t     req_tag;                          // tag field of the request
   cache_pkg::tag_t     tag_mem [N_SETS][`CACHE_N_WAYS];  // stored tag of every way of every set
   cache_pkg::way_vec_t valid_mem [N_SETS];               // valid bit of every way of every set
   logic                fill_en;                          // a miss installs the new tag this edge

   // split the address, index in the low bits and tag above it
   assign idx     = addr[`CACHE_IDX_W-1:0];
   assign req_tag = addr[`CACHE_ADDR_W-1:`CACHE_IDX_W];

   assign way_valid = valid_mem[idx];                     // read straight from the registers

   always_comb
   begin
      for (int w = 0; w < `CACHE_N_WAYS; w++)
      begin
         // only a valid way can hit, stale tags after flush are ignored
         way_hit[w] = way_valid[w] && (tag_mem[idx][w] == req_tag);
      end
   end

   assign fill_en = req && !flush && !(|way_hit);         // a hit leaves the tags alone

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int s = 0; s < N_SETS; s++)
         begin
            valid_mem[s] <= '0;                           // empty directory after reset
         end
      end
      else if (flush)
      begin
         for (int s = 0; s < N_SETS; s++)
         begin
            valid_mem[s] <= '0;                           // invalidate every line at once
         end
      end
      else if (fill_en)
      begin
         valid_mem[idx] <= valid_mem[idx] | fill_way;     // the filled way becomes valid
      end
   end

   always_ff @(posedge clk)
   begin
      if (fill_en)
      begin
         for (int w = 0; w < `CACHE_N_WAYS; w++)
         begin
            if (fill_way[w])
            begin
               tag_mem[idx][w] <= req_tag;                // victim or free way takes the new tag
            end
         end
      end
   end

   // a tag is only looked at while its valid bit is set
   // so flush has no need to touch the tag array

endmodule

// ==== testbench/tb_cache_directory.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_cache_directory;

   localparam int N_SETS      = 1 << `CACHE_IDX_W;
   localparam int RSP_TIMEOUT = 10;                       // cycles a directed lookup may wait

   logic                clk;
   logic                arst_n;
   logic                req;
   cache_pkg::addr_t    addr;
   logic                flush;
   logic                rsp_valid;
   logic                rsp_hit;
   cache_pkg::way_num_t rsp_way;

   cache_pkg::tag_t m_tag [N_SETS][`CACHE_N_WAYS];        // reference copy of the tag array
   bit              m_valid [N_SETS][`CACHE_N_WAYS];
   int              m_stamp [N_SETS][`CACHE_N_WAYS];      // time of last use, smallest is LRU
   int              m_time;
   int              pred_hit;                             // model answer for the driven request
   int              pred_way;
   int              exp_valid;                            // model answer moved to the response cycle
   int              exp_hit;
   int              exp_way;
   bit              seen_req;                             // set once the first request is sampled
   int              check_count;
   int              value_errors;
   int              protocol_errors;
   integer          seed;

   cache_directory #(
      .REP_POLICY (`POLICY_LRU)
   ) dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (req),
      .addr      (addr),
      .flush     (flush),
      .rsp_valid (rsp_valid),
      .rsp_hit   (rsp_hit),
      .rsp_way   (rsp_way)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;                              // 8 ns period
   end

   task automatic compare_value(input string what, input int got, input int want);
      check_count++;
      assert (got == want)
      else
      begin
         value_errors++;
         $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, want);
      end
   endtask

   task automatic note_error(input string msg);
      protocol_errors++;
      $display("ERROR %0t: %s", $time, msg);
   endtask

   task automatic print_counts();
      $display("checks %0d, value errors %0d, protocol errors %0d",
               check_count, value_errors, protocol_errors);
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      print_counts();
      $display("TESTS FAILED");
      $finish;
   endtask

   function automatic cache_pkg::addr_t make_addr(input int tag, input int set);
      return {cache_pkg::tag_t'(tag), cache_pkg::idx_t'(set)};
   endfunction

   task automatic model_flush();
      for (int s = 0; s < N_SETS; s++)
      begin
         for (int w = 0; w < `CACHE_N_WAYS; w++)
         begin
            m_valid[s][w] = 1'b0;
         end
      end
   endtask

   // hit way, else lowest free way, else the least recently used way
   task automatic model_request(input cache_pkg::addr_t a);
      cache_pkg::idx_t s;
      cache_pkg::tag_t t;
      int              free_way;
      s        = a[`CACHE_IDX_W-1:0];
      t        = a[`CACHE_ADDR_W-1:`CACHE_IDX_W];
      pred_hit = 0;
      pred_way = 0;
      free_way = -1;
      for (int w = `CACHE_N_WAYS - 1; w >= 0; w--)
      begin
         if (m_valid[s][w] && m_tag[s][w] == t)
         begin
            pred_hit = 1;
            pred_way = w;
         end
         if (!m_valid[s][w])
         begin
            free_way = w;                                 // the scan ends on the lowest one
         end
      end
      if (pred_hit == 0)
      begin
         if (free_way >= 0)
         begin
            pred_way = free_way;
         end
         else
         begin
            for (int w = 1; w < `CACHE_N_WAYS; w++)
            begin
               if (m_stamp[s][w] < m_stamp[s][pred_way])
               begin
                  pred_way = w;
               end
            end
         end
         m_tag[s][pred_way]   = t;
         m_valid[s][pred_way] = 1'b1;
      end
      m_time++;
      m_stamp[s][pred_way] = m_time;                      // every request refreshes its way
   endtask

   // the prediction is taken at the edge that samples the request
   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         exp_valid <= 0;
         exp_hit   <= 0;
         exp_way   <= 0;
         seen_req  <= 1'b0;
      end
      else
      begin
         exp_valid <= int'(req && !flush);
         if (req && !flush)
         begin
            exp_hit  <= pred_hit;
            exp_way  <= pred_way;
            seen_req <= 1'b1;
         end
      end
   end

   // outputs are settled half a cycle after the edge
   always @(negedge clk)
   begin
      if (!seen_req)
      begin
         compare_value("idle rsp_valid", int'(rsp_valid), 0);
         compare_value("idle rsp_hit", int'(rsp_hit), 0);
         compare_value("idle rsp_way", int'(rsp_way), 0);
      end
      else if (arst_n)
      begin
         compare_value("rsp_valid", int'(rsp_valid), exp_valid);
         if (exp_valid != 0)
         begin
            compare_value("rsp_hit", int'(rsp_hit), exp_hit);
            compare_value("rsp_way", int'(rsp_way), exp_way);
         end
      end
   end

   rsp_after_req : assert property (@(posedge clk) disable iff (!arst_n)
      (req && !flush) |=> rsp_valid)
      else note_error("request gave no rsp_valid pulse one cycle later");

   no_stray_rsp : assert property (@(posedge clk) disable iff (!arst_n)
      !(req && !flush) |=> !rsp_valid)
      else note_error("rsp_valid pulsed without a request");

   task automatic drive_idle();
      @(posedge clk);
      #1;
      req   = 1'b0;
      flush = 1'b0;
   endtask

   task automatic issue(input cache_pkg::addr_t a);
      @(posedge clk);
      #1;
      req   = 1'b1;
      flush = 1'b0;
      addr  = a;
      model_request(a);
   endtask

   task automatic lookup(input cache_pkg::addr_t a, input int want_hit, input int want_way);
      int waited;
      issue(a);
      drive_idle();
      waited = 0;
      while (!rsp_valid && waited < RSP_TIMEOUT)
      begin
         @(negedge clk);
         waited++;
      end
      if (!rsp_valid)
      begin
         abort_run("timeout, no response arrived for a directed lookup");
      end
      else
      begin
         compare_value("directed hit", int'(rsp_hit), want_hit);
         compare_value("directed way", int'(rsp_way), want_way);
      end
   endtask

   task automatic do_flush();
      @(posedge clk);
      #1;
      req   = 1'b0;
      flush = 1'b1;
      model_flush();
      drive_idle();
   endtask

   // back to back requests over six tags and four sets, with a rare flush
   task automatic random_traffic(input int count);
      logic [31:0] r;
      for (int i = 0; i < count; i++)
      begin
         r = $random(seed);
         @(posedge clk);
         #1;
         flush = (r[15:10] == 6'd0);
         req   = (r[4:2] != 3'd0);
         addr  = make_addr('h40 + int'(r[18:16]) % 6, int'(r[21:20]));
         if (flush)
         begin
            model_flush();                                // flush wins over a request in its cycle
         end
         else if (req)
         begin
            model_request(addr);
         end
      end
      drive_idle();
   endtask

   initial
   begin
      seed            = 32'h8b6c;
      req             = 1'b0;
      flush           = 1'b0;
      addr            = '0;
      arst_n          = 1'b0;
      check_count     = 0;
      value_errors    = 0;
      protocol_errors = 0;
      m_time          = 0;
      model_flush();
      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;
      repeat (4) drive_idle();                            // outputs stay zero before any request
      lookup(make_addr('h11, 2), 0, 0);
      lookup(make_addr('h11, 2), 1, 0);
      lookup(make_addr('h12, 2), 0, 1);
      lookup(make_addr('h11, 2), 1, 0);
      for (int t = 0; t < `CACHE_N_WAYS; t++)
      begin
         lookup(make_addr('h20 + t, 5), 0, t);            // free ways fill in order
      end
      lookup(make_addr('h20, 5), 1, 0);                   // way 0 is now the newest
      lookup(make_addr('h24, 5), 0, 1);
      lookup(make_addr('h25, 5), 0, 2);
      lookup(make_addr('h21, 5), 0, 3);
      lookup(make_addr('h20, 5), 1, 0);
      do_flush();
      lookup(make_addr('h11, 2), 0, 0);
      lookup(make_addr('h12, 2), 0, 1);
      lookup(make_addr('h20, 5), 0, 0);
      lookup(make_addr('h24, 5), 0, 1);
      lookup(make_addr('h25, 5), 0, 2);
      lookup(make_addr('h21, 5), 0, 3);
      random_traffic(400);
      repeat (4) drive_idle();
      print_counts();
      if (value_errors == 0 && protocol_errors == 0)
      begin
         $display("TESTS PASSED");
      end
      else
      begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+src
src/cache_pkg.sv
src/onehot_to_bin.sv
src/policy_mem.sv
src/tag_lookup.sv
src/replacement_process.sv
src/fill_select.sv
src/cache_directory.sv
testbench/tb_cache_directory.sv
